// File: flist.f
+incdir+hw
hw/scratch_pkg.sv
hw/ram_sdp_bw.sv
hw/sweep_counter.sv
hw/clear_fsm.sv
hw/scratch_mem_top.sv
testbench/scratch_mem_tb.sv

// File: Makefile
# Verilator build for the scratchpad memory

VERILATOR  ?= verilator
TOP        ?= scratch_mem_tb
RTL_TOP    ?= scratch_mem_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level, then the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

# Build and run, pass only when the pass line is printed
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/scratch_mem_tb.sv
// ------------------------------------------------
// Testbench for the scratchpad memory
//   shadow model of masked writes and clear sweep
//   random stimulus, output checks every cycle
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "scratch_settings.svh"

module scratch_mem_tb;

  localparam int          WORDS      = 2**`SCRATCH_ADDR_BITS;
  localparam logic [31:0] SEED       = 32'hc399_d27b;
  // Tests need under 2000 cycles, the rest is margin
  localparam int          MAX_CYCLES = 6000;

  // DUT ports
  logic                 clk;
  logic                 rst;
  logic                 clear;
  scratch_pkg::wr_req_t host_wr;
  logic                 rd_en;
  scratch_pkg::addr_t   rd_addr;
  scratch_pkg::data_t   rd_data;
  logic                 busy;
  logic                 done;

  // Shadow memory and clear engine model
  scratch_pkg::data_t   shadow [0:WORDS-1];
  logic                 m_busy;
  scratch_pkg::addr_t   m_sweep;

  // Expected outputs after the last sampled edge
  logic                 exp_busy;
  logic                 exp_done;
  logic                 have_rd;
  scratch_pkg::addr_t   exp_rd_addr;
  scratch_pkg::data_t   exp_rd_data;

  int error_count;
  int check_count;
  int busy_count;
  int done_count;
  int cycle_count = 0;

  scratch_mem_top scratch_mem_top_inst (
    .clk     (clk),
    .rst     (rst),
    .clear   (clear),
    .busy    (busy),
    .done    (done),
    .host_wr (host_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run hung, still going after %0d cycles", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------------------------
  // Reference model, one call per sampled edge
  // ------------------------------------------------

  task automatic model_edge(input logic clr, input scratch_pkg::wr_req_t w,
                            input logic re, input scratch_pkg::addr_t ra);
    // Read sees the word from before this edge's write
    if (re) begin
      have_rd     = 1'b1;
      exp_rd_addr = ra;
      exp_rd_data = shadow[ra];
    end
    exp_done = 1'b0;
    if (m_busy) begin
      // Sweep owns the port, host write is lost, clear ignored
      shadow[m_sweep] = '0;
      if (m_sweep == '1) begin
        m_busy   = 1'b0;
        exp_done = 1'b1;
      end
      m_sweep = m_sweep + 1'b1;
    end else begin
      if (w.en) begin
        for (int i = 0; i < `SCRATCH_WORD_BYTES; i++) begin
          if (w.mask[i]) begin
            shadow[w.addr][8*i +: 8] = w.data[8*i +: 8];
          end
        end
      end
      if (clr) begin
        m_busy  = 1'b1;
        m_sweep = '0;
      end
    end
    exp_busy = m_busy;
  endtask

  task automatic check_outputs();
    check_count = check_count + 2;
    assert (busy === exp_busy) else begin
      $display("error at %0t ns: busy is %b, expected %b", $time, busy, exp_busy);
      error_count++;
    end
    assert (done === exp_done) else begin
      $display("error at %0t ns: done is %b, expected %b", $time, done, exp_done);
      error_count++;
    end
    // Read data also has to hold between reads
    if (have_rd) begin
      check_count++;
      assert (rd_data === exp_rd_data) else begin
        $display("error at %0t ns: read of address %0d gave %h, expected %h",
                 $time, exp_rd_addr, rd_data, exp_rd_data);
        error_count++;
      end
    end
    if (busy === 1'b1) busy_count++;
    if (done === 1'b1) done_count++;
  endtask

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------

  // Drive on the rising edge, check at the falling edge,
  // then update the model for the next rising edge
  task automatic run_cycle(input logic clr, input scratch_pkg::wr_req_t w,
                           input logic re, input scratch_pkg::addr_t ra);
    clear   <= clr;
    host_wr <= w;
    rd_en   <= re;
    rd_addr <= ra;
    @(negedge clk);
    check_outputs();
    @(posedge clk);
    model_edge(clr, w, re, ra);
  endtask

  function automatic scratch_pkg::wr_req_t random_write(input logic full_mask);
    scratch_pkg::wr_req_t w;
    w.en   = 1'b1;
    w.addr = scratch_pkg::addr_t'($urandom_range(WORDS-1));
    w.data = scratch_pkg::data_t'($urandom());
    w.mask = full_mask ? '1 : scratch_pkg::mask_t'($urandom());
    return w;
  endfunction

  task automatic fill_all();
    scratch_pkg::wr_req_t w;
    for (int a = 0; a < WORDS; a++) begin
      w      = random_write(1'b1);
      w.addr = scratch_pkg::addr_t'(a);
      run_cycle(1'b0, w, 1'b0, '0);
    end
  endtask

  task automatic read_all();
    for (int a = 0; a < WORDS; a++) begin
      run_cycle(1'b0, '0, 1'b1, scratch_pkg::addr_t'(a));
    end
  endtask

  // Clear pulse, optional traffic, waits for done with a bound
  task automatic sweep_with_traffic(input logic host_writes, input logic reads,
                                    input int reclear_at);
    scratch_pkg::wr_req_t w;
    scratch_pkg::addr_t   ra;
    int                   n;
    n          = 0;
    busy_count = 0;
    done_count = 0;
    run_cycle(1'b1, '0, 1'b0, '0);
    while (done_count == 0 && n < 4 * WORDS) begin
      w  = host_writes ? random_write(1'b0) : '0;
      ra = scratch_pkg::addr_t'($urandom_range(WORDS-1));
      run_cycle(n == reclear_at, w, reads, ra);
      n++;
    end
    if (done_count == 0) begin
      $display("sweep failed: done never pulsed within %0d cycles", n);
      error_count++;
    end
    // Quiet cycles so a stray busy or second done shows up
    repeat (4) run_cycle(1'b0, '0, 1'b0, '0);
    assert (busy_count == WORDS) else begin
      $display("error at %0t ns: busy lasted %0d cycles, expected %0d",
               $time, busy_count, WORDS);
      error_count++;
    end
    assert (done_count == 1) else begin
      $display("error at %0t ns: done pulsed %0d cycles, expected 1", $time, done_count);
      error_count++;
    end
  endtask

  // Flush the last read check and print one line
  task automatic finish_test(input string name, input int errors_before);
    run_cycle(1'b0, '0, 1'b0, '0);
    $display("%s: %0d errors", name, error_count - errors_before);
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------

  initial begin
    scratch_pkg::wr_req_t w;
    scratch_pkg::addr_t   ra;
    logic                 re;
    int                   start_errors;
    void'($urandom(SEED));
    rst         = 1'b1;
    clear       = 1'b0;
    host_wr     = '0;
    rd_en       = 1'b0;
    rd_addr     = '0;
    m_busy      = 1'b0;
    m_sweep     = '0;
    exp_busy    = 1'b0;
    exp_done    = 1'b0;
    have_rd     = 1'b0;
    exp_rd_addr = '0;
    exp_rd_data = '0;
    error_count = 0;
    check_count = 0;
    busy_count  = 0;
    done_count  = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Full-mask fill, then every word back
    start_errors = error_count;
    fill_all();
    read_all();
    finish_test("fill and readback", start_errors);

    // Masked writes, reads often aimed at the write address
    start_errors = error_count;
    repeat (1000) begin
      w = '0;
      if ($urandom_range(3) != 0) w = random_write(1'b0);
      re = ($urandom_range(1) == 1);
      ra = scratch_pkg::addr_t'($urandom_range(WORDS-1));
      if ($urandom_range(3) == 0) ra = w.addr;
      run_cycle(1'b0, w, re, ra);
    end
    finish_test("byte mask merge", start_errors);

    start_errors = error_count;
    sweep_with_traffic(1'b0, 1'b0, -1);
    read_all();
    finish_test("clear sweep", start_errors);

    // Host writes during the sweep, then a few after done
    start_errors = error_count;
    sweep_with_traffic(1'b1, 1'b0, -1);
    read_all();
    repeat (16) run_cycle(1'b0, random_write(1'b0), 1'b0, '0);
    read_all();
    finish_test("writes dropped while busy", start_errors);

    // Second clear mid-sweep, random reads throughout
    start_errors = error_count;
    fill_all();
    sweep_with_traffic(1'b0, 1'b1, 30);
    finish_test("clear while busy and reads in sweep", start_errors);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/scratch_mem_top.sv
// ------------------------------------------------
// Scratchpad memory top level
//   clear engine, sweep counter, byte-masked RAM
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "scratch_settings.svh"

module scratch_mem_top (
  input  wire                       clk,
  input  wire                       rst,

  // Clear request and status
  input  wire                       clear,
  output logic                      busy,
  output logic                      done,

  // Host write port
  input  wire  scratch_pkg::wr_req_t host_wr,

  // Host read port
  input  wire                       rd_en,
  input  wire  scratch_pkg::addr_t  rd_addr,
  output scratch_pkg::data_t        rd_data
);

  // ------------------------------------------------
  // Internal connections
  // ------------------------------------------------

  // Counter handshake between engine and counter
  logic                 sweep_start;
  logic                 sweep_step;
  logic                 sweep_last;
  scratch_pkg::addr_t   sweep_addr;

  // Selected write request into the RAM
  scratch_pkg::wr_req_t ram_wr;

  // Clear engine, also selects the RAM write source
  clear_fsm clear_fsm_inst (
    .clk         (clk),
    .rst         (rst),
    .clear       (clear),
    .host_wr     (host_wr),
    .sweep_addr  (sweep_addr),
    .sweep_last  (sweep_last),
    .sweep_start (sweep_start),
    .sweep_step  (sweep_step),
    .ram_wr      (ram_wr),
    .busy        (busy),
    .done        (done)
  );

  // Address source for the clear sweep
  sweep_counter sweep_counter_inst (
    .clk   (clk),
    .rst   (rst),
    .start (sweep_start),
    .step  (sweep_step),
    .addr  (sweep_addr),
    .last  (sweep_last)
  );

  // Storage, read port goes straight to the host
  ram_sdp_bw #(
    .BYTE_WIDTH (`SCRATCH_WORD_BYTES),
    .ADDR_WIDTH (`SCRATCH_ADDR_BITS)
  ) ram_sdp_bw_inst (
    .clk     (clk),
    .wr      (ram_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: hw/clear_fsm.sv
// ------------------------------------------------
// Clear engine state machine
//   idle / sweep control of the address counter
//   RAM write port select, host or sweep
//   busy level and done pulse
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module clear_fsm (
  input  wire                       clk,
  input  wire                       rst,

  // Clear request, one-cycle pulse
  input  wire                       clear,

  // Host write request
  input  wire  scratch_pkg::wr_req_t host_wr,

  // Sweep counter interface
  input  wire  scratch_pkg::addr_t  sweep_addr,
  input  wire                       sweep_last,
  output logic                      sweep_start,
  output logic                      sweep_step,

  // RAM write port
  output scratch_pkg::wr_req_t      ram_wr,

  // Status
  output logic                      busy,
  output logic                      done
);

  scratch_pkg::clear_state_t state;
  scratch_pkg::clear_state_t state_next;

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------

  // Clear only counts in idle
  // A pulse during a sweep has no effect
  always_comb begin
    state_next = state;
    case (state)
      scratch_pkg::CLR_IDLE: begin
        if (clear) begin
          state_next = scratch_pkg::CLR_SWEEP;
        end
      end
      scratch_pkg::CLR_SWEEP: begin
        // Leave after the write at the top address
        if (sweep_last) begin
          state_next = scratch_pkg::CLR_IDLE;
        end
      end
      default: begin
        state_next = scratch_pkg::CLR_IDLE;
      end
    endcase
  end

  // ------------------------------------------------
  // State and done registers
  // ------------------------------------------------

  // Done is set on the edge that writes the last word
  // so it is high in the cycle after busy falls
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= scratch_pkg::CLR_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= (state == scratch_pkg::CLR_SWEEP) && sweep_last;
    end
  end

  // ------------------------------------------------
  // Counter control and status
  // ------------------------------------------------

  // Counter loads zero on the accepted clear edge
  // then advances once per sweep cycle
  always_comb begin
    sweep_start = (state == scratch_pkg::CLR_IDLE) && clear;
    sweep_step  = (state == scratch_pkg::CLR_SWEEP);
    busy        = (state == scratch_pkg::CLR_SWEEP);
  end

  // ------------------------------------------------
  // RAM write source
  // ------------------------------------------------

  // Sweep owns the port while busy
  // Host requests in that window are simply lost
  always_comb begin
    if (state == scratch_pkg::CLR_SWEEP) begin
      ram_wr.en   = 1'b1;
      ram_wr.addr = sweep_addr;
      ram_wr.data = '0;
      ram_wr.mask = '1;
    end else begin
      ram_wr = host_wr;
    end
  end

endmodule

`default_nettype wire

// File: hw/sweep_counter.sv
// ------------------------------------------------
// Address counter for the clear sweep
//   load to zero, step by one
//   last-address flag
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module sweep_counter (
  input  wire                       clk,
  input  wire                       rst,

  // Control from the clear engine
  input  wire                       start,
  input  wire                       step,

  // Current sweep address and end flag
  output scratch_pkg::addr_t        addr,
  output logic                      last
);

  // ------------------------------------------------
  // Address register
  // ------------------------------------------------

  // Start wins over step when both are high
  // Stepping past the top wraps back to zero
  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
    end else if (start) begin
      addr <= '0;
    end else if (step) begin
      addr <= addr + 1'b1;
    end
  end

  // ------------------------------------------------
  // Last-address decode
  // ------------------------------------------------

  // High while the address is all ones
  // i.e. the final word of the sweep
  always_comb begin
    last = &addr;
  end

endmodule

`default_nettype wire

// File: hw/ram_sdp_bw.sv
// ------------------------------------------------
// Simple dual port RAM
//   write port with per-byte mask
//   read port with registered output
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "scratch_settings.svh"

module ram_sdp_bw #(
  parameter int BYTE_WIDTH = `SCRATCH_WORD_BYTES,
  parameter int ADDR_WIDTH = `SCRATCH_ADDR_BITS
) (
  input  wire                         clk,

  // Write port
  input  wire  scratch_pkg::wr_req_t  wr,

  // Read port
  input  wire                         rd_en,
  input  wire  scratch_pkg::addr_t    rd_addr,
  output scratch_pkg::data_t          rd_data
);

  // Storage array, one entry per word address
  logic [BYTE_WIDTH*8-1:0] mem [0:2**ADDR_WIDTH-1];

  // ------------------------------------------------
  // Write port
  // ------------------------------------------------

  // Only the lanes with a set mask bit are updated
  // Other bytes of the word keep their contents
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int i = 0; i < BYTE_WIDTH; i++) begin
        if (wr.mask[i]) begin
          mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
        end
      end
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------

  // One cycle latency, output holds between reads
  // A write to the same address on the same edge is
  // not seen here, so the old word comes out
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: hw/scratch_pkg.sv
// ------------------------------------------------
// Shared types of the scratchpad memory
//   address, word and byte mask vectors
//   write request struct
//   clear engine state encoding
// ------------------------------------------------

`default_nettype none

`include "scratch_settings.svh"

package scratch_pkg;

  // Word address into the RAM
  typedef logic [`SCRATCH_ADDR_BITS-1:0] addr_t;

  // One memory word, eight bits per byte lane
  typedef logic [8*`SCRATCH_WORD_BYTES-1:0] data_t;

  // Byte enables, bit i covers data bits [8*i+7:8*i]
  typedef logic [`SCRATCH_WORD_BYTES-1:0] mask_t;

  // One write on the RAM write port
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
    mask_t mask;
  } wr_req_t;

  // Clear engine states
  typedef enum logic [0:0] {
    CLR_IDLE  = 1'b0,
    CLR_SWEEP = 1'b1
  } clear_state_t;

endpackage

`default_nettype wire

// File: hw/scratch_settings.svh
// ------------------------------------------------
// Build-time sizes of the scratchpad memory
//   word size in bytes
//   word address width
// ------------------------------------------------

`ifndef SCRATCH_SETTINGS_SVH
`define SCRATCH_SETTINGS_SVH

// Bytes per memory word, one mask bit each
`define SCRATCH_WORD_BYTES 4

// Word address bits, 6 gives 64 words
// Clear sweep length follows this width
`define SCRATCH_ADDR_BITS 6

`endif
